//--- Makefile
TOP := uart_link_tb

.PHONY: run lint clean

run:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "^=== PASS ===$$"

lint:
	verilator --lint-only -Wall -Ihw hw/uart_pkg.sv hw/uart_tx.sv hw/uart_rx.sv \
		hw/uart_link.sv --top-module uart_link

clean:
	rm -rf obj_dir

//--- filelist.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_link.sv
verif/uart_link_chk.sv
verif/uart_link_tb.sv

//--- hw/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Clock cycles per line bit, 50 MHz clock at 19200 baud.
`define UART_BAUD_DIV 2604

// Line bits in one frame: start, eight data bits and stop.
`define UART_FRAME_BITS 10

// Level of the serial line while nothing is being sent.
`define UART_IDLE 1'b1

`endif

//--- hw/uart_link.sv
`include "uart_consts.svh"

module uart_link import uart_pkg::*; #(
  parameter int BAUD_DIV = `UART_BAUD_DIV // Clock cycles per line bit, both sides.
) (
  input  logic       clk,      // System clock.
  input  logic       rst_n,    // Asynchronous active low reset.
  input  logic       trmt,     // Starts a transmit frame.
  input  uart_byte_t tx_data,  // Byte to send.
  output logic       tx_done,  // Transmit frame finished.
  output logic       tx,       // Serial line out.
  input  logic       rx,       // Serial line in.
  input  logic       clr_rdy,  // Received byte has been read.
  output logic       rdy,      // Received frame waiting.
  output uart_rx_t   rx_frame  // Received byte and framing flag.
);

  // Transmit half of the link.
  uart_tx #(
    .BAUD_DIV (BAUD_DIV)
  ) tx_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .trmt    (trmt),
    .tx_data (tx_data),
    .tx_done (tx_done),
    .tx      (tx)
  );

  // Receive half; its line is separate so it can be looped back outside.
  uart_rx #(
    .BAUD_DIV (BAUD_DIV)
  ) rx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .clr_rdy  (clr_rdy),
    .rdy      (rdy),
    .rx_frame (rx_frame)
  );

endmodule

//--- hw/uart_pkg.sv
package uart_pkg;

  ////////////////////////////////////////////////////////////////////
  // Payload types shared by the transmitter, receiver and top level.
  ////////////////////////////////////////////////////////////////////

  typedef logic [7:0] uart_byte_t; // One data byte as it travels on the line.

  // What the receiver hands back once a frame has been taken in.
  typedef struct packed {
    uart_byte_t data;      // Byte assembled from the eight data bits.
    logic       frame_err; // High when the sampled stop bit was 0.
  } uart_rx_t;

endpackage

//--- hw/uart_rx.sv
`include "uart_consts.svh"

module uart_rx import uart_pkg::*; #(
  parameter int BAUD_DIV = `UART_BAUD_DIV // Clock cycles per line bit.
) (
  input  logic     clk,      // System clock.
  input  logic     rst_n,    // Asynchronous active low reset.
  input  logic     rx,       // Serial line in, asynchronous to clk.
  input  logic     clr_rdy,  // One-cycle strobe, the byte has been read.
  output logic     rdy,      // Level, rx_frame holds a new frame.
  output uart_rx_t rx_frame  // Received byte and framing flag.
);

  localparam int CNT_W  = $clog2(BAUD_DIV);              // Baud counter width.
  localparam int BIT_W  = $clog2(`UART_FRAME_BITS + 1);  // Sample counter width.
  localparam int DATA_W = $bits(uart_byte_t);            // Data bits per frame.

  typedef enum logic {IDLE, RCV} state_t; // Watching for a start edge, or sampling.

  ////////////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////////////
  logic              rx_meta;   // First synchronizer stage.
  logic              rx_sync;   // Second stage, safe to use in logic.
  logic              rx_prev;   // Synced line one cycle earlier.
  logic              rx_fall;   // High on the first low cycle after high.
  logic [CNT_W-1:0]  baud_cnt;  // Cycles left until the next sample.
  logic [BIT_W-1:0]  bit_cnt;   // Samples taken in this frame.
  logic              start;     // Start edge seen while idle.
  logic              sample;    // Mid-cell, take the line value.
  logic              done;      // Stop bit sampled, frame complete.
  uart_byte_t        rx_shft;   // Data bits, newest at the top.
  logic              frame_err; // Stop bit came in low.
  state_t            state;     // Current FSM state.
  state_t            nxt_state; // FSM state for the next cycle.

  // Two flops against metastability; both preset to idle so reset is not a start.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= `UART_IDLE;
      rx_sync <= `UART_IDLE;
      rx_prev <= `UART_IDLE;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync; // Kept for edge detection.
    end
  end

  assign rx_fall = rx_prev && !rx_sync; // Line has just dropped.

  ////////////////////////////////////////////////////////////////////
  // Sample timing
  ////////////////////////////////////////////////////////////////////

  // Down counter. Half a period reaches mid start bit, then full periods.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (start)
      baud_cnt <= CNT_W'(BAUD_DIV / 2 - 1); // Lands in the middle of the start bit.
    else if (sample)
      baud_cnt <= CNT_W'(BAUD_DIV - 1); // One cell on to the next middle.
    else if (state == RCV)
      baud_cnt <= baud_cnt - 1'b1;
  end

  // Counts samples; sample 0 is the start bit, the last is the stop bit.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (start)
      bit_cnt <= '0;
    else if (sample)
      bit_cnt <= bit_cnt + 1'b1;
  end

  assign start  = (state == IDLE) && rx_fall;
  assign sample = (state == RCV) && (baud_cnt == '0);
  assign done   = sample && (bit_cnt == BIT_W'(`UART_FRAME_BITS - 1));

  // Every sample but the stop bit enters at the top; the start bit falls off the end.
  always_ff @(posedge clk) begin
    if (sample && !done)
      rx_shft <= {rx_sync, rx_shft[DATA_W-1:1]};
  end

  // Stop bit must be at the idle level.
  always_ff @(posedge clk) begin
    if (done)
      frame_err <= (rx_sync != `UART_IDLE);
  end

  // Clear wins over set, so rdy cannot rise in a clr_rdy cycle.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rdy <= 1'b0;
    else if (start || clr_rdy)
      rdy <= 1'b0; // Read, or a new frame is on its way.
    else if (done)
      rdy <= 1'b1;
  end

  assign rx_frame = '{data: rx_shft, frame_err: frame_err}; // Valid while rdy is high.

  ////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state; // Hold by default.
    case (state)
      RCV: begin
        if (done)
          nxt_state = IDLE; // Back to watching for the next start edge.
      end
      default: begin
        if (start)
          nxt_state = RCV;
      end
    endcase
  end

endmodule

//--- hw/uart_tx.sv
`include "uart_consts.svh"

module uart_tx import uart_pkg::*; #(
  parameter int BAUD_DIV = `UART_BAUD_DIV // Clock cycles per line bit.
) (
  input  logic       clk,     // System clock.
  input  logic       rst_n,   // Asynchronous active low reset.
  input  logic       trmt,    // One-cycle strobe that starts a frame.
  input  uart_byte_t tx_data, // Byte to send, sampled with trmt.
  output logic       tx_done, // Level, high from frame end until next start.
  output logic       tx       // Serial line out.
);

  localparam int CNT_W  = $clog2(BAUD_DIV);              // Baud counter width.
  localparam int BIT_W  = $clog2(`UART_FRAME_BITS + 1);  // Bit counter width.
  localparam int SHFT_W = $bits(uart_byte_t) + 1;        // Data byte plus start bit.

  typedef enum logic {IDLE, TRM} state_t; // Waiting for trmt, or sending a frame.

  ////////////////////////////////////////////////////////////////////
  // Internal signals
  ////////////////////////////////////////////////////////////////////
  logic [SHFT_W-1:0] tx_shft;      // Bits still to go out, LSB on the line.
  logic [CNT_W-1:0]  baud_cnt;     // Cycles spent on the current bit.
  logic [BIT_W-1:0]  bit_cnt;      // Bits already shifted out.
  logic              init;         // Loads a new frame.
  logic              shift;        // Moves on to the next line bit.
  logic              transmitting; // High for the whole frame.
  logic              set_done;     // Last bit has run its full period.
  state_t            state;        // Current FSM state.
  state_t            nxt_state;    // FSM state for the next cycle.

  // Load puts the start bit at the bottom; idle level fills in from the top.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_shft <= {SHFT_W{`UART_IDLE}}; // Line idles high out of reset.
    else if (init)
      tx_shft <= {tx_data, 1'b0}; // Byte above a 0 start bit.
    else if (shift)
      tx_shft <= {`UART_IDLE, tx_shft[SHFT_W-1:1]}; // Stop bit and idle follow.
  end

  // Counts the cycles of one bit, restarting for every new bit.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      baud_cnt <= '0;
    else if (init || shift)
      baud_cnt <= '0; // Fresh bit period.
    else if (transmitting)
      baud_cnt <= baud_cnt + 1'b1; // Still holding the current bit.
  end

  // Counts line bits so the frame ends after the stop bit.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (init)
      bit_cnt <= '0; // New frame, nothing sent yet.
    else if (shift)
      bit_cnt <= bit_cnt + 1'b1; // One more bit has gone out.
  end

  assign transmitting = (state == TRM); // Counter runs only inside a frame.
  assign shift = transmitting && (baud_cnt == CNT_W'(BAUD_DIV - 1)); // Bit period up.
  assign tx = tx_shft[0]; // Bottom of the register drives the line.

  ////////////////////////////////////////////////////////////////////
  // FSM and done flag
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  // Set/clear flop, cleared on the edge where the next start bit goes out.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      tx_done <= 1'b0;
    else if (init)
      tx_done <= 1'b0; // A new frame has begun.
    else if (set_done)
      tx_done <= 1'b1; // Stop bit has run its full period.
  end

  always_comb begin
    nxt_state = state; // Hold by default.
    init      = 1'b0;
    set_done  = 1'b0;
    case (state)
      TRM: begin
        // The tenth shift ends the stop bit.
        if (shift && (bit_cnt == BIT_W'(`UART_FRAME_BITS - 1))) begin
          set_done  = 1'b1;
          nxt_state = IDLE;
        end
      end
      default: begin
        if (trmt) begin // A trmt during TRM never reaches here, so it is dropped.
          init      = 1'b1;
          nxt_state = TRM;
        end
      end
    endcase
  end

endmodule

//--- verif/uart_link_chk.sv
module uart_link_chk import uart_pkg::*; (
  input logic     clk,      // System clock.
  input logic     rst_n,    // Asynchronous active low reset.
  input logic     trmt,     // Transmit start strobe.
  input logic     tx_done,  // Transmit done level.
  input logic     tx,       // Serial line out.
  input logic     clr_rdy,  // Receive clear strobe.
  input logic     rdy,      // Receive ready level.
  input uart_rx_t rx_frame  // Received byte and framing flag.
);

  timeunit 1ns;
  timeprecision 1ps;

  // Stop bit and idle level both keep the line high once a frame is done.
  done_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    tx_done |-> tx)
    else $error("tx low while tx_done is high");

  // Only a start of the next frame clears tx_done.
  done_falls_on_trmt: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(tx_done) |-> $past(trmt))
    else $error("tx_done fell without a trmt strobe");

  // Clear has priority over a finishing frame.
  rdy_not_set_on_clear: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rdy) |-> !$past(clr_rdy))
    else $error("rdy rose in a clr_rdy cycle");

  rx_frame_held: assert property (@(posedge clk) disable iff (!rst_n)
    (rdy && $past(rdy)) |-> $stable(rx_frame))
    else $error("rx_frame changed while rdy was high");

endmodule

// Attach the checker to every uart_link, where both halves' ports meet.
bind uart_link uart_link_chk chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .trmt     (trmt),
  .tx_done  (tx_done),
  .tx       (tx),
  .clr_rdy  (clr_rdy),
  .rdy      (rdy),
  .rx_frame (rx_frame)
);

//--- verif/uart_link_tb.sv
`include "uart_consts.svh"

module uart_link_tb import uart_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BIT_CYC    = 16;           // Clock cycles per line bit in this bench.
  localparam int WAIT_LIMIT = 30 * BIT_CYC; // Longest any single wait may run.
  localparam int RAND_BYTES = 24;
  localparam uart_byte_t FIXED_BYTES [4] = '{8'h00, 8'hFF, 8'h55, 8'hA5};

  logic       clk = 1'b0;
  logic       rst_n;
  logic       trmt;
  uart_byte_t tx_data;
  logic       tx_done;
  logic       tx;
  logic       rx;
  logic       clr_rdy;
  logic       rdy;
  uart_rx_t   rx_frame;
  logic       loopback;      // High routes tx straight back into rx.
  logic       bb_line;       // Line level driven by bang_frame.
  logic       manual_clr;    // Comparator leaves rdy set for the test to clear.
  uart_rx_t   exp_q [$];     // Frames still expected, oldest first.
  int         sent = 0;      // Frames expected so far.
  int         rx_count = 0;  // Frames seen by the comparator.
  int         checks = 0;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  integer     seed = 32'hf81e0d89;

  always #20 clk = ~clk; // 40 ns period.

  assign rx = loopback ? tx : bb_line; // Line mux in front of the receiver.

  uart_link #(.BAUD_DIV(BIT_CYC)) dut_i (.*);

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  function automatic uart_rx_t expected_frame(input uart_byte_t b, input logic stop);
    uart_rx_t f;
    f.data      = b;              // Data comes through unchanged.
    f.frame_err = (stop == 1'b0); // A low stop bit is a framing error.
    return f;
  endfunction

  function automatic logic sig_value(input string name);
    return (name == "tx_done") ? tx_done : rdy;
  endfunction

  task automatic check_frame(input uart_rx_t got, input uart_rx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: rx_frame data %h frame_err %b, expected data %h frame_err %b",
               $time, got.data, got.frame_err, exp.data, exp.frame_err);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string name);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bounded waits and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_signal(input string name, input logic level);
    int cycles;
    cycles = 0;
    @(negedge clk); // A flop updated on the last rising edge has settled here.
    while (sig_value(name) !== level && cycles < WAIT_LIMIT) begin
      @(negedge clk); // Outputs are settled mid-cycle.
      cycles++;
    end
    if (sig_value(name) !== level) begin
      $display("Timeout: %s did not reach %b within %0d cycles", name, level, WAIT_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  endtask

  task automatic wait_frames(input int n);
    int cycles;
    cycles = 0;
    while (rx_count < n && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (rx_count < n) begin
      $display("Timeout: only %0d of %0d frames arrived within %0d cycles", rx_count, n,
               WAIT_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  endtask

  task automatic expect_byte(input uart_byte_t b, input logic stop);
    exp_q.push_back(expected_frame(b, stop));
    sent++;
  endtask

  task automatic start_frame(input uart_byte_t b);
    @(posedge clk);
    trmt    <= 1'b1; // One-cycle strobe.
    tx_data <= b;
    @(posedge clk);
    trmt    <= 1'b0;
  endtask

  task automatic send_and_wait(input uart_byte_t b);
    expect_byte(b, `UART_IDLE);
    start_frame(b);
    wait_signal("tx_done", 1'b1); // Frame fully on the line.
  endtask

  task automatic bang_and_wait(input uart_byte_t b, input logic stop);
    logic [`UART_FRAME_BITS-1:0] bits;
    bits = {stop, b, 1'b0}; // Start bit goes out first, then LSB first.
    expect_byte(b, stop);
    @(posedge clk);
    for (int i = 0; i < `UART_FRAME_BITS; i++) begin
      bb_line <= bits[i];
      repeat (BIT_CYC) @(posedge clk); // Each bit held one full period.
    end
    bb_line <= `UART_IDLE;
    repeat (2 * BIT_CYC) @(posedge clk); // Idle gap so the next start edge is clean.
    wait_frames(sent);
  endtask

  task automatic report_test(input string name, input int start_err);
    tests_run++;
    if (errors == start_err) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - start_err);
    end
  endtask

  // Takes each frame as rdy shows it and matches it against the queue.
  initial begin : compare_frames
    forever begin
      @(negedge clk);
      if (rdy) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Received a frame at %0t although none was sent", $time);
        end else begin
          check_frame(rx_frame, exp_q.pop_front());
        end
        rx_count++;
        if (!manual_clr) begin
          @(posedge clk);
          clr_rdy <= 1'b1;
          @(posedge clk);
          clr_rdy <= 1'b0;
        end
        wait_signal("rdy", 1'b0); // Do not count the same frame twice.
      end
    end
  end

  initial begin : run_tests
    int   start_err;
    int   start_cnt;
    logic high_seen;

    rst_n      <= 1'b0;
    trmt       <= 1'b0;
    tx_data    <= '0;
    clr_rdy    <= 1'b0;
    bb_line    <= `UART_IDLE;
    loopback   = 1'b1;
    manual_clr = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    start_err = errors;
    @(negedge clk);
    check_level(tx, 1'b1, "tx after reset");
    check_level(tx_done, 1'b0, "tx_done after reset");
    check_level(rdy, 1'b0, "rdy after reset");
    report_test("reset values", start_err);

    start_err = errors;
    foreach (FIXED_BYTES[i]) begin
      send_and_wait(FIXED_BYTES[i]);
      wait_frames(sent);
      repeat (BIT_CYC) @(negedge clk); // tx_done is a level and holds until the next start.
      check_level(tx_done, 1'b1, "tx_done after frame");
    end
    report_test("fixed bytes in loopback", start_err);

    start_err = errors;
    repeat (RAND_BYTES) send_and_wait(uart_byte_t'($random(seed)));
    wait_frames(sent);
    check_level(exp_q.size() == 0, 1'b1, "all random bytes received");
    report_test("random bytes back to back", start_err);

    start_err = errors;
    start_cnt = rx_count;
    expect_byte(8'h3C, `UART_IDLE);
    start_frame(8'h3C);
    repeat (4 * BIT_CYC) @(posedge clk); // Well inside the data bits.
    start_frame(8'hC3);                  // The transmitter is busy and drops this one.
    wait_signal("tx_done", 1'b1);
    wait_frames(sent);
    repeat (12 * BIT_CYC) @(posedge clk); // Room for a stray second frame to show up.
    check_level(rx_count == start_cnt + 1, 1'b1, "one frame for two trmt pulses");
    check_level(tx, `UART_IDLE, "tx idle after dropped trmt");
    report_test("trmt ignored mid-frame", start_err);

    start_err = errors;
    loopback = 1'b0; // Both lines idle high, so no false edge.
    bang_and_wait(8'h5A, 1'b0);
    bang_and_wait(8'h81, 1'b0);
    bang_and_wait(8'h96, 1'b1);
    loopback = 1'b1;
    report_test("framing errors", start_err);

    start_err = errors;
    manual_clr = 1'b1;
    send_and_wait(8'hE7);
    wait_frames(sent);
    check_level(rdy, 1'b1, "rdy before clr_rdy");
    @(posedge clk);
    clr_rdy <= 1'b1;
    @(posedge clk);
    clr_rdy <= 1'b0;
    high_seen = 1'b0;
    repeat (4 * BIT_CYC) begin
      @(negedge clk);
      high_seen = high_seen | rdy;
    end
    check_level(high_seen, 1'b0, "rdy after clr_rdy");
    manual_clr = 1'b0;
    send_and_wait(8'h18); // Next frame sets rdy again.
    wait_frames(sent);
    report_test("clr_rdy clears rdy", start_err);

    check_level(exp_q.size() == 0, 1'b1, "no frames left outstanding");
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
